// File: hdl/mips_pkg.sv
package mips_pkg;

    // ####################
    // Widths
    // ####################

    typedef logic [31:0] word_t;     // Data word or byte address.
    typedef logic [4:0]  reg_idx_t;  // Register file index.
    typedef logic [4:0]  shamt_t;    // Shift amount field.
    typedef logic [15:0] imm_t;      // Raw immediate field.
    typedef logic [25:0] jidx_t;     // J instruction index.

    // ####################
    // Operations
    // ####################

    typedef enum logic [4:0] {
        OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL,
        OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI,
        OP_LW, OP_SW,
        OP_BEQ, OP_BNE, OP_J, OP_JR,
        OP_INVALID                   // Unsupported encodings run as a no-op.
    } op_t;

    typedef enum logic [1:0] {
        S_FETCH,                     // Instruction read at pc.
        S_EXEC1,                     // ALU writeback and branch resolve.
        S_EXEC2,                     // Data access and pc update.
        S_HALTED
    } seq_state_t;

    // ####################
    // Addresses
    // ####################

    localparam word_t RESET_VECTOR = 32'hBFC0_0000;  // First fetch.
    localparam word_t HALT_ADDRESS = 32'h0000_0000;  // Jumping here stops the core.

endpackage

// File: hdl/cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  logic       halted,
    output seq_state_t state,
    output logic       active
);

    seq_state_t state_next;

    always_comb begin
        case (state)
            S_FETCH: state_next = S_EXEC1;
            S_EXEC1: state_next = S_EXEC2;
            S_EXEC2: state_next = halted ? S_HALTED : S_FETCH;  // End of delay slot.
            default: state_next = S_HALTED;                     // Halt is final.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_FETCH;
        end else if (!stall) begin
            state <= state_next;                                 // Hold on bus wait.
        end
    end

    assign active = (state != S_HALTED);

endmodule

// File: hdl/program_counter.sv
`timescale 1ns/1ps

module program_counter
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  seq_state_t state,
    input  op_t        op,
    input  imm_t       imm,
    input  jidx_t      jump_index,
    input  word_t      rs_data,
    input  logic       equal,
    input  logic       stall,
    output word_t      pc,
    output logic       halted
);

    word_t pc_plus4, target, pc_load, pending_target;
    logic  taken, pending_valid, slot_armed, halt_q, capture, exec2_done;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        taken  = 1'b0;
        target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};  // Relative to delay slot.
        case (op)
            OP_BEQ: taken = equal;
            OP_BNE: taken = !equal;
            OP_J: begin
                taken  = 1'b1;
                target = {pc_plus4[31:28], jump_index, 2'b00};
            end
            OP_JR: begin
                taken  = 1'b1;
                target = rs_data;
            end
            default: ;
        endcase
    end

    // A branch sitting in a delay slot is ignored.
    assign capture    = (state == S_EXEC1) && taken && !slot_armed;
    assign exec2_done = (state == S_EXEC2) && !stall;
    assign pc_load    = slot_armed ? pending_target : pc_plus4;
    assign halted     = halt_q || (exec2_done && pc_load == HALT_ADDRESS);

    always_ff @(posedge clk) begin
        if (capture) begin
            pending_target <= target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc            <= RESET_VECTOR;
            pending_valid <= 1'b0;
            slot_armed    <= 1'b0;
            halt_q        <= 1'b0;
        end else begin
            if (capture) begin
                pending_valid <= 1'b1;
            end
            if (exec2_done) begin
                pc            <= pc_load;
                slot_armed    <= pending_valid;   // Next instruction is the delay slot.
                pending_valid <= 1'b0;
                halt_q        <= halted;
            end
        end
    end

endmodule

// File: hdl/instr_decode.sv
`timescale 1ns/1ps

module instr_decode
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  seq_state_t state,
    input  logic       stall,
    input  word_t      readdata,
    output op_t        op,
    output reg_idx_t   rs,
    output reg_idx_t   rt,
    output reg_idx_t   rd_idx,
    output imm_t       imm,
    output shamt_t     shamt,
    output jidx_t      jump_index
);

    word_t      instr;
    logic [5:0] opcode, funct;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr <= '0;                                // Encodes a NOP.
        end else if (state == S_FETCH && !stall) begin
            instr <= readdata;                          // Completed fetch.
        end
    end

    assign opcode     = instr[31:26];
    assign funct      = instr[5:0];
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign rd_idx     = instr[15:11];
    assign shamt      = instr[10:6];
    assign imm        = instr[15:0];
    assign jump_index = instr[25:0];

    always_comb begin
        op = OP_INVALID;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h00:   op = OP_SLL;
                    6'h02:   op = OP_SRL;
                    6'h08:   op = OP_JR;
                    6'h21:   op = OP_ADDU;
                    6'h23:   op = OP_SUBU;
                    6'h24:   op = OP_AND;
                    6'h25:   op = OP_OR;
                    6'h26:   op = OP_XOR;
                    6'h2A:   op = OP_SLT;
                    6'h2B:   op = OP_SLTU;
                    default: op = OP_INVALID;
                endcase
            end
            6'h02:   op = OP_J;
            6'h04:   op = OP_BEQ;
            6'h05:   op = OP_BNE;
            6'h09:   op = OP_ADDIU;
            6'h0A:   op = OP_SLTI;
            6'h0C:   op = OP_ANDI;
            6'h0D:   op = OP_ORI;
            6'h0E:   op = OP_XORI;
            6'h0F:   op = OP_LUI;
            6'h23:   op = OP_LW;
            6'h2B:   op = OP_SW;
            default: op = OP_INVALID;
        endcase
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu
    import mips_pkg::*;
(
    input  op_t    op,
    input  word_t  a,
    input  word_t  b,
    input  shamt_t shamt,
    output word_t  result,
    output logic   equal
);

    always_comb begin
        case (op)
            OP_ADDU, OP_ADDIU, OP_LW, OP_SW: result = a + b;  // Also the data address.
            OP_SUBU:                         result = a - b;
            OP_AND, OP_ANDI:                 result = a & b;
            OP_OR, OP_ORI:                   result = a | b;
            OP_XOR, OP_XORI:                 result = a ^ b;
            OP_SLT, OP_SLTI:                 result = word_t'($signed(a) < $signed(b));
            OP_SLTU:                         result = word_t'(a < b);
            OP_SLL:                          result = b << shamt;  // Shifts take rt.
            OP_SRL:                          result = b >> shamt;
            OP_LUI:                          result = {b[15:0], 16'h0000};
            default:                         result = '0;
        endcase
    end

    assign equal = (a == b);                                 // BEQ and BNE.

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     write_en,
    input  reg_idx_t write_idx,
    input  word_t    write_data,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    v0
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};                          // Programs start from zero.
        end else if (write_en && write_idx != 5'd0) begin
            regs[write_idx] <= write_data;                   // r0 stays zero.
        end
    end

    assign rs_data = regs[rs];
    assign rt_data = regs[rt];
    assign v0      = regs[2];

endmodule

// File: hdl/mem_access.sv
`timescale 1ns/1ps

module mem_access
    import mips_pkg::*;
(
    input  seq_state_t state,
    input  op_t        op,
    input  word_t      pc,
    input  word_t      alu_result,
    input  word_t      rt_data,
    input  logic       waitrequest,
    input  word_t      readdata,
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writedata,
    output word_t      load_data,
    output logic       stall
);

    always_comb begin
        address = pc;
        read    = 1'b0;
        write   = 1'b0;
        case (state)
            S_FETCH: read = 1'b1;                            // Instruction fetch.
            S_EXEC2: begin
                if (op == OP_LW) begin
                    address = alu_result;
                    read    = 1'b1;
                end else if (op == OP_SW) begin
                    address = alu_result;
                    write   = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign writedata = rt_data;                              // Held steady by the stall.
    assign load_data = readdata;
    assign stall     = (read || write) && waitrequest;

endmodule

// File: hdl/mips_cpu_bus.sv
`timescale 1ns/1ps

module mips_cpu_bus
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output logic  active,
    output word_t register_v0,

    output word_t address,
    output logic  write,
    output logic  read,
    input  logic  waitrequest,
    output word_t writedata,
    input  word_t readdata
);

    seq_state_t state;
    op_t        op;
    reg_idx_t   rs, rt, rd_idx, write_idx;
    imm_t       imm;
    shamt_t     shamt;
    jidx_t      jump_index;
    word_t      rs_data, rt_data, alu_b, result, load_data, pc, write_data;
    logic       equal, stall, halted, alu_write, write_en;

    // ####################
    // Datapath muxes
    // ####################

    always_comb begin
        case (op)
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: alu_b = {16'h0000, imm};  // Zero extended.
            OP_ADDIU, OP_SLTI, OP_LW, OP_SW:  alu_b = {{16{imm[15]}}, imm};
            default:                          alu_b = rt_data;
        endcase
    end

    always_comb begin
        alu_write = 1'b0;
        write_idx = rd_idx;
        case (op)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR,
            OP_SLT, OP_SLTU, OP_SLL, OP_SRL: alu_write = 1'b1;
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI: begin
                alu_write = 1'b1;
                write_idx = rt;                                       // I-type target.
            end
            OP_LW:   write_idx = rt;
            default: ;
        endcase
    end

    // ALU results land in EXEC1, loads once the bus read completes.
    assign write_en   = (state == S_EXEC1 && alu_write) ||
                        (state == S_EXEC2 && op == OP_LW && !stall);
    assign write_data = (op == OP_LW) ? load_data : result;

    // ####################
    // Blocks
    // ####################

    cycle_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .stall(stall), .halted(halted),
        .state(state), .active(active)
    );

    program_counter u_pc (
        .clk(clk), .rst_n(rst_n), .state(state), .op(op), .imm(imm),
        .jump_index(jump_index), .rs_data(rs_data), .equal(equal),
        .stall(stall), .pc(pc), .halted(halted)
    );

    instr_decode u_dec (
        .clk(clk), .rst_n(rst_n), .state(state), .stall(stall),
        .readdata(readdata), .op(op), .rs(rs), .rt(rt), .rd_idx(rd_idx),
        .imm(imm), .shamt(shamt), .jump_index(jump_index)
    );

    alu u_alu (
        .op(op), .a(rs_data), .b(alu_b), .shamt(shamt),
        .result(result), .equal(equal)
    );

    register_file u_regs (
        .clk(clk), .rst_n(rst_n), .write_en(write_en), .write_idx(write_idx),
        .write_data(write_data), .rs(rs), .rt(rt), .rs_data(rs_data),
        .rt_data(rt_data), .v0(register_v0)
    );

    mem_access u_mem (
        .state(state), .op(op), .pc(pc), .alu_result(result),
        .rt_data(rt_data), .waitrequest(waitrequest), .readdata(readdata),
        .address(address), .read(read), .write(write),
        .writedata(writedata), .load_data(load_data), .stall(stall)
    );

endmodule

// File: bench/avalon_ram_model.sv
`timescale 1ns/1ps

module avalon_ram_model
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  word_t address,
    input  logic  read,
    input  logic  write,
    input  word_t writedata,
    output logic  waitrequest,
    output word_t readdata
);

    localparam int MAX_WAIT = 3;  // Longest waitrequest stretch in cycles.

    word_t mem [512];             // Data words near zero, then code at the reset vector.
    logic  in_xfer;
    logic  running;
    int    wait_left;

    function automatic logic mapped(input word_t addr);
        return (addr[31:10] == 22'h0) || (addr[31:10] == RESET_VECTOR[31:10]);
    endfunction

    function automatic int slot(input word_t addr);
        return int'({addr[31], addr[9:2]});
    endfunction

    function automatic word_t fill(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    task automatic clear_mem();
        int    i;
        word_t addr;
        for (i = 0; i < 512; i++) begin
            addr   = (i < 256) ? word_t'(4 * i) : RESET_VECTOR + word_t'(4 * (i - 256));
            mem[i] = fill(addr);
        end
    endtask

    task automatic load_word(input word_t addr, input word_t data);
        if (mapped(addr)) begin
            mem[slot(addr)] = data;
        end
    endtask

    function automatic word_t read_word(input word_t addr);
        return mapped(addr) ? mem[slot(addr)] : fill(addr);
    endfunction

    initial begin
        waitrequest = 1'b1;
        readdata    = '0;
        in_xfer     = 1'b0;
        wait_left   = 0;
    end

    always @(posedge clk) begin
        running = rst_n;
        if (running && in_xfer && !waitrequest) begin
            if (write) begin
                load_word(address, writedata);           // Write lands on the final edge.
            end
            in_xfer = 1'b0;
        end
        #2;
        if (!running) begin
            in_xfer     = 1'b0;
            waitrequest = 1'b1;                          // Busy while in reset.
        end else begin
            if ((read || write) && !in_xfer) begin
                in_xfer   = 1'b1;
                wait_left = $urandom % (MAX_WAIT + 1);
            end else if (wait_left > 0) begin
                wait_left = wait_left - 1;
            end
            waitrequest = in_xfer && (wait_left > 0);
        end
        readdata = read_word(address);
    end

endmodule

// File: bench/mips_cpu_assertions.sv
`timescale 1ns/1ps

module mips_cpu_assertions
    import mips_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       read,
    input logic       write,
    input logic       waitrequest,
    input word_t      address,
    input word_t      writedata,
    input logic       active,
    input seq_state_t state
);

    // ####################
    // Avalon master rules
    // ####################

    a_one_direction: assert property (@(posedge clk) disable iff (!rst_n) !(read && write))
        else $error("read and write high in the same cycle");

    a_hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (read || write) && waitrequest |=> $stable(address) && $stable(writedata) &&
            $stable(read) && $stable(write))
        else $error("transfer changed while waitrequest was high");

    // ####################
    // Reset and halt
    // ####################

    // First edge out of reset must find the core fetching, with no store on the bus.
    a_fetch_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> state == S_FETCH && active && !write)
        else $error("core not fetching on the first cycle after reset");

    a_halt_is_final: assert property (@(posedge clk) disable iff (!rst_n) !active |=> !active)
        else $error("active rose again after halt");

endmodule

bind mips_cpu_bus mips_cpu_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .read(read), .write(write), .waitrequest(waitrequest),
    .address(address), .writedata(writedata), .active(active), .state(state)
);

// File: bench/tb_mips_cpu_bus.sv
`timescale 1ns/1ps

module tb_mips_cpu_bus
    import mips_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int MAX_WAIT   = 3;     // Matches the RAM model.
    localparam int NUM_TESTS  = 9;
    localparam int MAX_STEPS  = 4000;  // Model guard against runaway programs.
    localparam int DATA_WORDS = 256;

    logic  clk, rst_n, active, read, write, waitrequest;
    word_t register_v0, address, writedata, readdata;

    word_t prog [$];
    word_t model_regs [32];
    word_t model_data [DATA_WORDS];
    int    errors, checks, post_halt_xfers;
    logic  first_read_seen, watch_armed;
    word_t first_read_addr;
    time   deadline;

    mips_cpu_bus dut (
        .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .readdata(readdata)
    );

    avalon_ram_model ram (
        .clk(clk), .rst_n(rst_n), .address(address), .read(read), .write(write),
        .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ####################
    // Checks and monitors
    // ####################

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, expected, actual);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && read && !first_read_seen) begin
            first_read_seen = 1'b1;
            first_read_addr = address;
        end
        if (rst_n && !active && (read || write)) begin
            post_halt_xfers++;                               // Halted core must stay silent.
        end
    end

    always @(posedge clk) begin
        if (watch_armed && $time > deadline) begin
            $display("Timeout: core still active at %0t, limit was %0t", $time, deadline);
            $display("Errors found");
            $finish;
        end
    end

    // ####################
    // Program generation
    // ####################

    function automatic word_t enc_r(input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
                                    input shamt_t sh, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, sh, funct};
    endfunction

    function automatic word_t enc_i(input logic [5:0] opcode, input reg_idx_t rs,
                                    input reg_idx_t rt, input imm_t imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic reg_idx_t pick_reg(input int count);
        return reg_idx_t'($urandom % count);
    endfunction

    function automatic word_t random_alu_instr();
        reg_idx_t rs, rt, rd;
        imm_t     imm;
        rs  = pick_reg(8);                                   // r0 included as a target.
        rt  = pick_reg(8);
        rd  = pick_reg(8);
        imm = imm_t'($urandom);
        case ($urandom % 15)
            0:       return enc_r(rs, rt, rd, 5'd0, 6'h21);
            1:       return enc_r(rs, rt, rd, 5'd0, 6'h23);
            2:       return enc_r(rs, rt, rd, 5'd0, 6'h24);
            3:       return enc_r(rs, rt, rd, 5'd0, 6'h25);
            4:       return enc_r(rs, rt, rd, 5'd0, 6'h26);
            5:       return enc_r(rs, rt, rd, 5'd0, 6'h2A);
            6:       return enc_r(rs, rt, rd, 5'd0, 6'h2B);
            7:       return enc_r(5'd0, rt, rd, shamt_t'($urandom), 6'h00);
            8:       return enc_r(5'd0, rt, rd, shamt_t'($urandom), 6'h02);
            9:       return enc_i(6'h09, rs, rt, imm);
            10:      return enc_i(6'h0C, rs, rt, imm);
            11:      return enc_i(6'h0D, rs, rt, imm);
            12:      return enc_i(6'h0E, rs, rt, imm);
            13:      return enc_i(6'h0A, rs, rt, imm);
            default: return enc_i(6'h0F, 5'd0, rt, imm);
        endcase
    endfunction

    task automatic build_program(input int kind);
        int    i, skip, sel;
        word_t here, target;
        prog.delete();
        case (kind)
            0: begin
                for (i = 0; i < 24; i++) begin
                    prog.push_back(random_alu_instr());
                end
            end
            1: begin
                for (i = 1; i < 8; i++) begin
                    prog.push_back(enc_i(6'h09, 5'd0, reg_idx_t'(i), imm_t'($urandom)));
                end
                for (i = 0; i < 24; i++) begin
                    sel = $urandom % 3;
                    if (sel == 0) begin
                        prog.push_back(random_alu_instr());
                    end else begin
                        prog.push_back(enc_i((sel == 1) ? 6'h23 : 6'h2B, 5'd0, pick_reg(8),
                                             imm_t'(16'h0100 + 4 * ($urandom % 16))));
                    end
                end
            end
            default: begin
                for (i = 0; i < 6; i++) begin
                    prog.push_back(enc_i(6'h09, 5'd0, reg_idx_t'(1 + $urandom % 3),
                                         imm_t'($urandom % 3)));
                    skip   = 1 + $urandom % 3;
                    sel    = $urandom % 3;
                    here   = RESET_VECTOR + word_t'(4 * prog.size());
                    target = here + word_t'(8 + 4 * skip);   // Just past the skipped block.
                    if (sel == 2) begin
                        prog.push_back({6'h02, target[27:2]});
                    end else begin
                        prog.push_back(enc_i((sel == 0) ? 6'h04 : 6'h05,
                                             reg_idx_t'(1 + $urandom % 3),
                                             reg_idx_t'(1 + $urandom % 3), imm_t'(skip + 1)));
                    end
                    prog.push_back(enc_i(6'h09, 5'd3, 5'd3, 16'd1));  // Delay slot counter.
                    repeat (skip) begin
                        prog.push_back(enc_i(6'h09, 5'd2, 5'd2, 16'd1));
                    end
                end
            end
        endcase
        // Dump every register to memory, then jump to zero.
        for (i = 1; i < 32; i++) begin
            prog.push_back(enc_i(6'h2B, 5'd0, reg_idx_t'(i), imm_t'(16'h0200 + 4 * i)));
        end
        prog.push_back(enc_i(6'h09, 5'd0, 5'd26, 16'd0));
        prog.push_back(enc_r(5'd26, 5'd0, 5'd0, 5'd0, 6'h08));
        prog.push_back(32'h0000_0000);
    endtask

    // ####################
    // ISA reference model
    // ####################

    function automatic void set_reg(input reg_idx_t idx, input word_t value);
        if (idx != 5'd0) begin
            model_regs[idx] = value;
        end
    endfunction

    task automatic run_model(output int steps);
        word_t    pc, npc, next_npc, instr, a, b, sx, zx, addr;
        reg_idx_t rs, rt, rd;
        int       idx;
        pc    = RESET_VECTOR;
        npc   = RESET_VECTOR + 32'd4;
        steps = 0;
        for (idx = 0; idx < 32; idx++) begin
            model_regs[idx] = '0;
        end
        while (pc != HALT_ADDRESS && steps < MAX_STEPS) begin
            idx      = int'((pc - RESET_VECTOR) >> 2);
            instr    = (idx < prog.size()) ? prog[idx] : 32'h0;
            rs       = instr[25:21];
            rt       = instr[20:16];
            rd       = instr[15:11];
            a        = model_regs[rs];
            b        = model_regs[rt];
            sx       = {{16{instr[15]}}, instr[15:0]};
            zx       = {16'h0000, instr[15:0]};
            addr     = a + sx;
            next_npc = npc + 32'd4;
            case (instr[31:26])
                6'h00: begin
                    case (instr[5:0])
                        6'h00:   set_reg(rd, b << instr[10:6]);
                        6'h02:   set_reg(rd, b >> instr[10:6]);
                        6'h08:   next_npc = a;
                        6'h21:   set_reg(rd, a + b);
                        6'h23:   set_reg(rd, a - b);
                        6'h24:   set_reg(rd, a & b);
                        6'h25:   set_reg(rd, a | b);
                        6'h26:   set_reg(rd, a ^ b);
                        6'h2A:   set_reg(rd, {31'b0, $signed(a) < $signed(b)});
                        6'h2B:   set_reg(rd, {31'b0, a < b});
                        default: ;
                    endcase
                end
                6'h02: next_npc = {npc[31:28], instr[25:0], 2'b00};
                6'h04: next_npc = (a == b) ? npc + (sx << 2) : next_npc;
                6'h05: next_npc = (a != b) ? npc + (sx << 2) : next_npc;
                6'h09: set_reg(rt, a + sx);
                6'h0A: set_reg(rt, {31'b0, $signed(a) < $signed(sx)});
                6'h0C: set_reg(rt, a & zx);
                6'h0D: set_reg(rt, a | zx);
                6'h0E: set_reg(rt, a ^ zx);
                6'h0F: set_reg(rt, {instr[15:0], 16'h0000});
                6'h23: set_reg(rt, model_data[addr[9:2]]);
                6'h2B: model_data[addr[9:2]] = b;
                default: ;
            endcase
            pc  = npc;
            npc = next_npc;
            steps++;
        end
    endtask

    // ####################
    // Test sequence
    // ####################

    task automatic run_test(input int num);
        string name;
        int    steps, errors_before, i;
        name          = (num % 3 == 0) ? "alu" : (num % 3 == 1) ? "load_store" : "branch";
        name          = $sformatf("%s_%0d", name, num);
        errors_before = errors;
        build_program(num % 3);
        ram.clear_mem();
        for (i = 0; i < prog.size(); i++) begin
            ram.load_word(RESET_VECTOR + word_t'(4 * i), prog[i]);
        end
        for (i = 0; i < DATA_WORDS; i++) begin
            model_data[i] = $urandom;
            ram.load_word(word_t'(4 * i), model_data[i]);
        end
        run_model(steps);
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        first_read_seen = 1'b0;
        post_halt_xfers = 0;
        rst_n           = 1'b1;
        // Each instruction has up to two transfers, each with its own wait stretch.
        deadline    = $time + steps * (3 + 2 * MAX_WAIT) * CLK_PERIOD * 2;
        watch_armed = 1'b1;
        @(negedge clk);
        while (active) begin
            @(negedge clk);
        end
        watch_armed = 1'b0;
        repeat (10) @(negedge clk);                          // Watch the bus after halt.
        check_word({name, " reset_vector"}, RESET_VECTOR, first_read_addr);
        check_bit({name, " active"}, 1'b0, active);
        check_bit({name, " bus_idle_after_halt"}, 1'b1, post_halt_xfers == 0);
        check_word({name, " v0"}, model_regs[2], register_v0);
        for (i = 0; i < DATA_WORDS; i++) begin
            check_word($sformatf("%s mem[%h]", name, 4 * i), model_data[i],
                       ram.read_word(word_t'(4 * i)));
        end
        $display("test %-14s %0d steps, %s", name, steps,
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int t;
        void'($urandom(58475));
        clk             = 1'b0;
        rst_n           = 1'b0;
        errors          = 0;
        checks          = 0;
        post_halt_xfers = 0;
        first_read_seen = 1'b0;
        first_read_addr = '0;
        watch_armed     = 1'b0;
        deadline        = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests: %0d, checks: %0d, failed checks: %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/mips_pkg.sv
hdl/cycle_sequencer.sv
hdl/program_counter.sv
hdl/instr_decode.sv
hdl/alu.sv
hdl/register_file.sv
hdl/mem_access.sv
hdl/mips_cpu_bus.sv
bench/avalon_ram_model.sv
bench/mips_cpu_assertions.sv
bench/tb_mips_cpu_bus.sv
